//--- common/controlPkg.sv
`default_nettype none

package controlPkg;

   // Field and bus widths
   localparam int StateWidth  = 5;
   localparam int OpcodeWidth = 4;
   localparam int FunctWidth  = 4;
   localparam int AluOpWidth  = 3;
   localparam int CountWidth  = 17;
   localparam int PcSrcWidth  = 3;
   localparam int SelWidth    = 2;

   // FSM state codes
   localparam logic [StateWidth-1:0] StFetch       = 5'd0;
   localparam logic [StateWidth-1:0] StDecode      = 5'd1;
   localparam logic [StateWidth-1:0] StAlu3        = 5'd2;
   localparam logic [StateWidth-1:0] StImm3        = 5'd3;
   localparam logic [StateWidth-1:0] StMem3        = 5'd4;  // shared by lw and sw
   localparam logic [StateWidth-1:0] StBeq3        = 5'd5;
   localparam logic [StateWidth-1:0] StBne3        = 5'd6;
   localparam logic [StateWidth-1:0] StJump3       = 5'd7;
   localparam logic [StateWidth-1:0] StJr3         = 5'd8;
   localparam logic [StateWidth-1:0] StJal3        = 5'd9;
   localparam logic [StateWidth-1:0] StLui3        = 5'd10;
   localparam logic [StateWidth-1:0] StAlu4        = 5'd11;
   localparam logic [StateWidth-1:0] StImm4        = 5'd12;
   localparam logic [StateWidth-1:0] StLoad4       = 5'd13;
   localparam logic [StateWidth-1:0] StStore4      = 5'd14;
   localparam logic [StateWidth-1:0] StJal4        = 5'd15;
   localparam logic [StateWidth-1:0] StLoad5       = 5'd16;
   localparam logic [StateWidth-1:0] StMove        = 5'd17;
   localparam logic [StateWidth-1:0] StClear       = 5'd18;
   localparam logic [StateWidth-1:0] StRead        = 5'd19;
   localparam logic [StateWidth-1:0] StDisplay     = 5'd20;
   localparam logic [StateWidth-1:0] StBlank       = 5'd21;  // idle step before Fetch
   localparam logic [StateWidth-1:0] StPrepDisplay = 5'd22;

   // Register ALU ops
   localparam logic [OpcodeWidth-1:0] OpAdd     = 4'd0;
   localparam logic [OpcodeWidth-1:0] OpSub     = 4'd1;
   localparam logic [OpcodeWidth-1:0] OpOr      = 4'd2;
   localparam logic [OpcodeWidth-1:0] OpAnd     = 4'd3;
   localparam logic [OpcodeWidth-1:0] OpSlt     = 4'd7;

   // Immediate ALU ops
   localparam logic [OpcodeWidth-1:0] OpAddi    = 4'd4;
   localparam logic [OpcodeWidth-1:0] OpOri     = 4'd6;

   localparam logic [OpcodeWidth-1:0] OpSpecial = 4'd5;  // split by function code
   localparam logic [OpcodeWidth-1:0] OpLw      = 4'd8;
   localparam logic [OpcodeWidth-1:0] OpSw      = 4'd9;
   localparam logic [OpcodeWidth-1:0] OpLui     = 4'd10;
   localparam logic [OpcodeWidth-1:0] OpBeq     = 4'd11;
   localparam logic [OpcodeWidth-1:0] OpBne     = 4'd12;
   localparam logic [OpcodeWidth-1:0] OpJal     = 4'd13;
   localparam logic [OpcodeWidth-1:0] OpJ       = 4'd14;
   localparam logic [OpcodeWidth-1:0] OpJr      = 4'd15;

   // Special group function codes
   localparam logic [FunctWidth-1:0] FnMove    = 4'd0;
   localparam logic [FunctWidth-1:0] FnClear   = 4'd1;
   localparam logic [FunctWidth-1:0] FnRead    = 4'd2;
   localparam logic [FunctWidth-1:0] FnDisplay = 4'd3;

   // ALU control codes
   localparam logic [AluOpWidth-1:0] AluOr  = 3'd0;
   localparam logic [AluOpWidth-1:0] AluAnd = 3'd1;
   localparam logic [AluOpWidth-1:0] AluAdd = 3'd2;
   localparam logic [AluOpWidth-1:0] AluSub = 3'd6;
   localparam logic [AluOpWidth-1:0] AluSlt = 3'd7;

   // PC mux sources
   localparam logic [PcSrcWidth-1:0] PcFromReg    = 3'd0;
   localparam logic [PcSrcWidth-1:0] PcFromAlu    = 3'd1;
   localparam logic [PcSrcWidth-1:0] PcFromBranch = 3'd2;
   localparam logic [PcSrcWidth-1:0] PcFromVector = 3'd3;  // interrupt entry
   localparam logic [PcSrcWidth-1:0] PcFromClear  = 3'd4;
   localparam logic [PcSrcWidth-1:0] PcFromJump   = 3'd5;

   // Memory address mux
   localparam logic [SelWidth-1:0] AddrPc      = 2'd0;
   localparam logic [SelWidth-1:0] AddrAluOut  = 2'd1;
   localparam logic [SelWidth-1:0] AddrDisplay = 2'd2;

   // ALU B operand mux
   localparam logic [SelWidth-1:0] SrcBReg  = 2'd0;
   localparam logic [SelWidth-1:0] SrcBFour = 2'd1;
   localparam logic [SelWidth-1:0] SrcBImm  = 2'd2;
   localparam logic [SelWidth-1:0] SrcBLink = 2'd3;

endpackage

`default_nettype wire

//--- control/stateSequencer.sv
`default_nettype none

module stateSequencer (
   input  logic                               CLK,
   input  logic                               Reset,
   input  logic [controlPkg::OpcodeWidth-1:0] Opcode,
   input  logic [controlPkg::FunctWidth-1:0]  Functioncode,
   output logic [controlPkg::StateWidth-1:0]  CurrentState,
   output logic [controlPkg::StateWidth-1:0]  NextState
);

   import controlPkg::*;

   always_ff @(posedge CLK or posedge Reset)
   begin
      if (Reset)
         CurrentState <= StFetch;
      else
         CurrentState <= NextState;
   end

   always_comb
   begin
      NextState = StFetch;  // most execute states end here
      case (CurrentState)
         StFetch:   NextState = StDecode;
         StDecode:
         begin
            case (Opcode)
               OpAdd, OpSub, OpOr, OpAnd, OpSlt: NextState = StAlu3;
               OpAddi, OpOri:                    NextState = StImm3;
               OpLw, OpSw:                       NextState = StMem3;
               OpLui:                            NextState = StLui3;
               OpBeq:                            NextState = StBeq3;
               OpBne:                            NextState = StBne3;
               OpJal:                            NextState = StJal3;
               OpJ:                              NextState = StJump3;
               OpJr:                             NextState = StJr3;
               OpSpecial:
               begin
                  case (Functioncode)
                     FnMove:    NextState = StMove;
                     FnClear:   NextState = StClear;
                     FnRead:    NextState = StRead;
                     FnDisplay: NextState = StPrepDisplay;
                     default:   NextState = StFetch;  // unknown function
                  endcase
               end
               default:                          NextState = StFetch;
            endcase
         end
         StAlu3:    NextState = StAlu4;
         StImm3:    NextState = StImm4;
         StJal3:    NextState = StJal4;
         StMem3:
         begin
            // Opcode still held from Decode
            case (Opcode)
               OpLw:    NextState = StLoad4;
               OpSw:    NextState = StStore4;
               default: NextState = StFetch;
            endcase
         end
         StLoad4:   NextState = StLoad5;
         StPrepDisplay: NextState = StDisplay;

         // Idle step before the next Fetch
         StStore4, StClear, StRead, StDisplay: NextState = StBlank;

         default:   NextState = StFetch;
      endcase
   end

endmodule

`default_nettype wire

//--- control/datapathDecoder.sv
`default_nettype none

module datapathDecoder (
   input  logic [controlPkg::StateWidth-1:0]  CurrentState,
   input  logic [controlPkg::OpcodeWidth-1:0] Opcode,
   input  logic                               InterruptIn,
   input  logic                               InterruptHandler,
   output logic [controlPkg::AluOpWidth-1:0]  ALUOp,
   output logic                               PCWriteBeq,
   output logic                               PCWriteBne,
   output logic                               PCWrite,
   output logic [controlPkg::SelWidth-1:0]    IorD,
   output logic                               IRegWrite,
   output logic [controlPkg::SelWidth-1:0]    WriteAddr,
   output logic [controlPkg::SelWidth-1:0]    WriteData,
   output logic                               SignExt,
   output logic                               GRegWrite,
   output logic                               ALUSrcA,
   output logic [controlPkg::SelWidth-1:0]    ALUSrcB,
   output logic [controlPkg::PcSrcWidth-1:0]  PCData,
   output logic                               MemWrite,
   output logic [controlPkg::SelWidth-1:0]    MemWriteData,
   output logic                               EPCWrite,
   output logic                               CLR,
   output logic                               LCDWrite
);

   import controlPkg::*;

   always_comb
   begin
      ALUOp        = AluOr;
      PCWriteBeq   = 1'b0;
      PCWriteBne   = 1'b0;
      PCWrite      = 1'b0;
      IorD         = AddrPc;
      IRegWrite    = 1'b0;
      WriteAddr    = 2'd0;
      WriteData    = 2'd0;
      SignExt      = 1'b0;
      GRegWrite    = 1'b0;
      ALUSrcA      = 1'b0;
      ALUSrcB      = SrcBReg;
      PCData       = PcFromReg;
      MemWrite     = 1'b0;
      MemWriteData = 2'd0;
      EPCWrite     = 1'b0;
      CLR          = 1'b0;
      LCDWrite     = 1'b0;

      case (CurrentState)
         StFetch:
         begin
            ALUOp     = AluAdd;  // PC + 4
            PCWrite   = 1'b1;
            IorD      = AddrPc;
            IRegWrite = 1'b1;
            ALUSrcB   = SrcBFour;
            // Take the interrupt only when not already in the handler
            if (InterruptIn && !InterruptHandler)
            begin
               EPCWrite = 1'b1;
               PCData   = PcFromVector;
            end
            else
               PCData = PcFromAlu;
         end
         StDecode:
         begin
            ALUOp   = AluAdd;  // branch target
            SignExt = 1'b1;
            ALUSrcB = SrcBImm;
         end
         StAlu3:
         begin
            case (Opcode)
               OpAdd:   ALUOp = AluAdd;
               OpSub:   ALUOp = AluSub;
               OpAnd:   ALUOp = AluAnd;
               OpSlt:   ALUOp = AluSlt;
               default: ALUOp = AluOr;
            endcase
            ALUSrcA = 1'b1;
            ALUSrcB = SrcBReg;
         end
         StImm3:
         begin
            case (Opcode)
               OpAddi:  ALUOp = AluAdd;
               OpOri:   ALUOp = AluOr;
               default: ALUOp = AluOr;
            endcase
            ALUSrcA = 1'b1;
            ALUSrcB = SrcBImm;
         end
         StMem3:
         begin
            ALUOp   = AluAdd;  // base + offset
            SignExt = 1'b1;
            ALUSrcA = 1'b1;
            ALUSrcB = SrcBImm;
         end
         StBeq3, StBne3:
         begin
            ALUOp      = AluSub;
            PCWriteBeq = (CurrentState == StBeq3);
            PCWriteBne = (CurrentState == StBne3);
            ALUSrcA    = 1'b1;
            PCData     = PcFromBranch;
         end
         StJump3:
         begin
            PCWrite = 1'b1;
            PCData  = PcFromJump;
         end
         StJr3:
         begin
            PCWrite = 1'b1;
            PCData  = PcFromReg;
         end
         StJal3:
         begin
            ALUOp   = AluAdd;
            ALUSrcB = SrcBLink;
         end
         StJal4:
         begin
            PCWrite   = 1'b1;
            PCData    = PcFromJump;
            WriteAddr = 2'd3;  // link register
            WriteData = 2'd2;
            GRegWrite = 1'b1;
         end
         StAlu4:
         begin
            WriteAddr = 2'd2;
            WriteData = 2'd2;
            GRegWrite = 1'b1;
         end
         StImm4:
         begin
            WriteData = 2'd2;  // ALU result
            GRegWrite = 1'b1;
         end
         StLui3:    GRegWrite = 1'b1;
         StLoad4:   IorD = AddrAluOut;
         StLoad5:
         begin
            WriteAddr = 2'd1;
            WriteData = 2'd1;  // memory data
            GRegWrite = 1'b1;
         end
         StStore4:
         begin
            IorD         = AddrAluOut;
            MemWrite     = 1'b1;
            MemWriteData = 2'd1;
         end
         StMove:
         begin
            WriteData = 2'd3;
            GRegWrite = 1'b1;
         end
         StClear:
         begin
            PCWrite = 1'b1;
            PCData  = PcFromClear;
            CLR     = 1'b1;
         end
         StRead:
         begin
            IorD         = AddrDisplay;
            MemWrite     = 1'b1;
            MemWriteData = 2'd2;
         end
         StPrepDisplay: IorD = AddrDisplay;  // address settles a cycle early
         StDisplay:
         begin
            IorD     = AddrDisplay;
            LCDWrite = 1'b1;
         end
         default:   ALUOp = AluOr;  // Blank and unused codes keep defaults
      endcase
   end

endmodule

`default_nettype wire

//--- hw/perfCounters.sv
`default_nettype none

module perfCounters (
   input  logic                              CLK,
   input  logic                              Reset,
   input  logic [controlPkg::StateWidth-1:0] CurrentState,
   output logic [controlPkg::CountWidth-1:0] InstructionCount,
   output logic [controlPkg::CountWidth-1:0] CycleCount
);

   import controlPkg::*;

   // Both counters wrap silently
   always_ff @(posedge CLK or posedge Reset)
   begin
      if (Reset)
      begin
         CycleCount       <= '0;
         InstructionCount <= '0;
      end
      else
      begin
         CycleCount <= CycleCount + CountWidth'(1);
         if (CurrentState == StFetch)  // one Fetch per instruction
            InstructionCount <= InstructionCount + CountWidth'(1);
      end
   end

endmodule

`default_nettype wire

//--- hw/multicycleControl.sv
`default_nettype none

module multicycleControl (
   input  logic                               CLK,
   input  logic                               Reset,
   input  logic [controlPkg::OpcodeWidth-1:0] Opcode,
   input  logic [controlPkg::FunctWidth-1:0]  Functioncode,
   input  logic                               InterruptIn,
   input  logic                               InterruptHandler,
   output logic [controlPkg::AluOpWidth-1:0]  ALUOp,
   output logic                               PCWriteBeq,
   output logic                               PCWriteBne,
   output logic                               PCWrite,
   output logic [controlPkg::SelWidth-1:0]    IorD,
   output logic                               IRegWrite,
   output logic [controlPkg::SelWidth-1:0]    WriteAddr,
   output logic [controlPkg::SelWidth-1:0]    WriteData,
   output logic                               SignExt,
   output logic                               GRegWrite,
   output logic                               ALUSrcA,
   output logic [controlPkg::SelWidth-1:0]    ALUSrcB,
   output logic [controlPkg::PcSrcWidth-1:0]  PCData,
   output logic                               MemWrite,
   output logic [controlPkg::SelWidth-1:0]    MemWriteData,
   output logic                               EPCWrite,
   output logic                               CLR,
   output logic                               LCDWrite,
   output logic [controlPkg::StateWidth-1:0]  CurrentState,
   output logic [controlPkg::StateWidth-1:0]  NextState,
   output logic [controlPkg::CountWidth-1:0]  InstructionCount,
   output logic [controlPkg::CountWidth-1:0]  CycleCount
);

   import controlPkg::*;

   stateSequencer stateSequencer_inst (
      .CLK          (CLK),
      .Reset        (Reset),
      .Opcode       (Opcode),
      .Functioncode (Functioncode),
      .CurrentState (CurrentState),
      .NextState    (NextState)
   );

   // Moore outputs, plus opcode and interrupt terms
   datapathDecoder datapathDecoder_inst (
      .CurrentState     (CurrentState),
      .Opcode           (Opcode),
      .InterruptIn      (InterruptIn),
      .InterruptHandler (InterruptHandler),
      .ALUOp            (ALUOp),
      .PCWriteBeq       (PCWriteBeq),
      .PCWriteBne       (PCWriteBne),
      .PCWrite          (PCWrite),
      .IorD             (IorD),
      .IRegWrite        (IRegWrite),
      .WriteAddr        (WriteAddr),
      .WriteData        (WriteData),
      .SignExt          (SignExt),
      .GRegWrite        (GRegWrite),
      .ALUSrcA          (ALUSrcA),
      .ALUSrcB          (ALUSrcB),
      .PCData           (PCData),
      .MemWrite         (MemWrite),
      .MemWriteData     (MemWriteData),
      .EPCWrite         (EPCWrite),
      .CLR              (CLR),
      .LCDWrite         (LCDWrite)
   );

   perfCounters perfCounters_inst (
      .CLK              (CLK),
      .Reset            (Reset),
      .CurrentState     (CurrentState),
      .InstructionCount (InstructionCount),
      .CycleCount       (CycleCount)
   );

endmodule

`default_nettype wire

//--- tests/multicycleControl_asserts.sv
`default_nettype none

module multicycleControl_asserts (
   input logic                              CLK,
   input logic                              Reset,
   input logic [controlPkg::StateWidth-1:0] CurrentState,
   input logic                              PCWriteBeq,
   input logic                              PCWriteBne,
   input logic                              MemWrite,
   input logic                              EPCWrite
);

   import controlPkg::*;

   branchExclusive: assert property (@(posedge CLK) disable iff (Reset)
      !(PCWriteBeq && PCWriteBne))
      else $error("PCWriteBeq and PCWriteBne high together");

   memWriteStates: assert property (@(posedge CLK) disable iff (Reset)
      MemWrite |-> (CurrentState == StStore4 || CurrentState == StRead))
      else $error("MemWrite outside store and read states");

   epcOnlyInFetch: assert property (@(posedge CLK) disable iff (Reset)
      EPCWrite |-> CurrentState == StFetch)
      else $error("EPCWrite outside Fetch");

   // Async reset forces Fetch
   resetToFetch: assert property (@(posedge CLK) Reset |-> CurrentState == StFetch)
      else $error("state not Fetch during reset");

endmodule

bind multicycleControl multicycleControl_asserts multicycleControl_asserts_inst (
   .CLK(CLK), .Reset(Reset), .CurrentState(CurrentState), .PCWriteBeq(PCWriteBeq),
   .PCWriteBne(PCWriteBne), .MemWrite(MemWrite), .EPCWrite(EPCWrite)
);

`default_nettype wire

//--- tests/multicycleControl_tb.sv
`default_nettype none

module multicycleControl_tb;

   import controlPkg::*;

   logic                   CLK;
   logic                   Reset;
   logic [OpcodeWidth-1:0] Opcode;
   logic [FunctWidth-1:0]  Functioncode;
   logic                   InterruptIn;
   logic                   InterruptHandler;

   logic [AluOpWidth-1:0]  ALUOp;
   logic                   PCWriteBeq;
   logic                   PCWriteBne;
   logic                   PCWrite;
   logic [SelWidth-1:0]    IorD;
   logic                   IRegWrite;
   logic [SelWidth-1:0]    WriteAddr;
   logic [SelWidth-1:0]    WriteData;
   logic                   SignExt;
   logic                   GRegWrite;
   logic                   ALUSrcA;
   logic [SelWidth-1:0]    ALUSrcB;
   logic [PcSrcWidth-1:0]  PCData;
   logic                   MemWrite;
   logic [SelWidth-1:0]    MemWriteData;
   logic                   EPCWrite;
   logic                   CLR;
   logic                   LCDWrite;
   logic [StateWidth-1:0]  CurrentState;
   logic [StateWidth-1:0]  NextState;
   logic [CountWidth-1:0]  InstructionCount;
   logic [CountWidth-1:0]  CycleCount;

   integer                 seed = 32'hed52a068;
   int                     instrDone = 0;
   int                     instrCycles = 0;
   logic [StateWidth-1:0]  mState;
   logic [StateWidth-1:0]  mNext;
   logic [CountWidth-1:0]  mCycles;
   logic [CountWidth-1:0]  mInstrs;

   multicycleControl multicycleControl_inst (
      .CLK(CLK), .Reset(Reset), .Opcode(Opcode), .Functioncode(Functioncode),
      .InterruptIn(InterruptIn), .InterruptHandler(InterruptHandler),
      .ALUOp(ALUOp), .PCWriteBeq(PCWriteBeq), .PCWriteBne(PCWriteBne), .PCWrite(PCWrite),
      .IorD(IorD), .IRegWrite(IRegWrite), .WriteAddr(WriteAddr), .WriteData(WriteData),
      .SignExt(SignExt), .GRegWrite(GRegWrite), .ALUSrcA(ALUSrcA), .ALUSrcB(ALUSrcB),
      .PCData(PCData), .MemWrite(MemWrite), .MemWriteData(MemWriteData),
      .EPCWrite(EPCWrite), .CLR(CLR), .LCDWrite(LCDWrite),
      .CurrentState(CurrentState), .NextState(NextState),
      .InstructionCount(InstructionCount), .CycleCount(CycleCount)
   );

   initial
   begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("ERR %s expected %0h actual %0h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   function automatic logic [AluOpWidth-1:0] aluCode(input logic [OpcodeWidth-1:0] op,
                                                     input logic imm);
      logic [AluOpWidth-1:0] code;
      case ({imm, op})
         {1'b0, OpAdd}:  code = AluAdd;
         {1'b0, OpSub}:  code = AluSub;
         {1'b0, OpAnd}:  code = AluAnd;
         {1'b0, OpSlt}:  code = AluSlt;
         {1'b1, OpAddi}: code = AluAdd;
         {1'b1, OpOri}:  code = AluOr;
         default:        code = AluOr;  // OpOr and anything unknown
      endcase
      return code;
   endfunction

   function automatic logic [StateWidth-1:0] nextState(input logic [StateWidth-1:0] st,
      input logic [OpcodeWidth-1:0] op, input logic [FunctWidth-1:0] fn);
      logic [StateWidth-1:0] nx;
      nx = StFetch;
      case (st)
         StFetch: nx = StDecode;
         StDecode:
         begin
            case (op)
               OpAdd, OpSub, OpOr, OpAnd, OpSlt: nx = StAlu3;
               OpAddi, OpOri: nx = StImm3;
               OpLw, OpSw: nx = StMem3;
               OpLui: nx = StLui3;
               OpBeq: nx = StBeq3;
               OpBne: nx = StBne3;
               OpJal: nx = StJal3;
               OpJ: nx = StJump3;
               OpJr: nx = StJr3;
               default:
                  if (fn == FnMove) nx = StMove;
                  else if (fn == FnClear) nx = StClear;
                  else if (fn == FnRead) nx = StRead;
                  else if (fn == FnDisplay) nx = StPrepDisplay;
            endcase
         end
         StAlu3: nx = StAlu4;
         StImm3: nx = StImm4;
         StJal3: nx = StJal4;
         StMem3: nx = (op == OpLw) ? StLoad4 : StStore4;
         StLoad4: nx = StLoad5;
         StPrepDisplay: nx = StDisplay;
         StStore4, StClear, StRead, StDisplay: nx = StBlank;
         default: nx = StFetch;
      endcase
      return nx;
   endfunction

   // Fetch to Fetch length per instruction
   function automatic int cyclesFor(input logic [OpcodeWidth-1:0] op,
                                    input logic [FunctWidth-1:0] fn);
      if (op == OpLw || op == OpSw)
         return 5;
      if (op == OpBeq || op == OpBne || op == OpJ || op == OpJr || op == OpLui)
         return 3;
      if (op != OpSpecial)
         return 4;
      case (fn)
         FnMove:            return 3;
         FnClear, FnRead:   return 4;
         FnDisplay:         return 5;
         default:           return 2;  // bounces back from Decode
      endcase
   endfunction

   // {ALUOp, Beq Bne PCWrite, IorD, IRegWrite, WriteAddr WriteData,
   //  SignExt GRegWrite ALUSrcA, ALUSrcB, PCData, MemWrite MemWriteData EPC CLR LCD}
   function automatic logic [26:0] controlWord(input logic [StateWidth-1:0] st,
      input logic [OpcodeWidth-1:0] op, input logic irq);
      logic [26:0] w;
      case (st)
         StFetch:
            w = {AluAdd, 3'b001, AddrPc, 1'b1, 4'h0, 3'b000, SrcBFour,
                 irq ? PcFromVector : PcFromAlu, 3'b000, irq, 2'b00};
         StDecode: w = {AluAdd, 3'b000, AddrPc, 1'b0, 4'h0, 3'b100, SrcBImm, PcFromReg, 6'o00};
         StAlu3:
            w = {aluCode(op, 1'b0), 3'b000, AddrPc, 1'b0, 4'h0, 3'b001, SrcBReg, PcFromReg, 6'o00};
         StImm3:
            w = {aluCode(op, 1'b1), 3'b000, AddrPc, 1'b0, 4'h0, 3'b001, SrcBImm, PcFromReg, 6'o00};
         StMem3: w = {AluAdd, 3'b000, AddrPc, 1'b0, 4'h0, 3'b101, SrcBImm, PcFromReg, 6'o00};
         StBeq3: w = {AluSub, 3'b100, AddrPc, 1'b0, 4'h0, 3'b001, SrcBReg, PcFromBranch, 6'o00};
         StBne3: w = {AluSub, 3'b010, AddrPc, 1'b0, 4'h0, 3'b001, SrcBReg, PcFromBranch, 6'o00};
         StJump3: w = {AluOr, 3'b001, AddrPc, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromJump, 6'o00};
         StJr3: w = {AluOr, 3'b001, AddrPc, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromReg, 6'o00};
         StJal3: w = {AluAdd, 3'b000, AddrPc, 1'b0, 4'h0, 3'b000, SrcBLink, PcFromReg, 6'o00};
         StJal4: w = {AluOr, 3'b001, AddrPc, 1'b0, 4'hE, 3'b010, SrcBReg, PcFromJump, 6'o00};
         StAlu4: w = {AluOr, 3'b000, AddrPc, 1'b0, 4'hA, 3'b010, SrcBReg, PcFromReg, 6'o00};
         StImm4: w = {AluOr, 3'b000, AddrPc, 1'b0, 4'h2, 3'b010, SrcBReg, PcFromReg, 6'o00};
         StLui3: w = {AluOr, 3'b000, AddrPc, 1'b0, 4'h0, 3'b010, SrcBReg, PcFromReg, 6'o00};
         StLoad4: w = {AluOr, 3'b000, AddrAluOut, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromReg, 6'o00};
         StLoad5: w = {AluOr, 3'b000, AddrPc, 1'b0, 4'h5, 3'b010, SrcBReg, PcFromReg, 6'o00};
         StStore4: w = {AluOr, 3'b000, AddrAluOut, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromReg, 6'o50};
         StMove: w = {AluOr, 3'b000, AddrPc, 1'b0, 4'h3, 3'b010, SrcBReg, PcFromReg, 6'o00};
         StClear: w = {AluOr, 3'b001, AddrPc, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromClear, 6'o02};
         StRead: w = {AluOr, 3'b000, AddrDisplay, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromReg, 6'o60};
         StPrepDisplay:
            w = {AluOr, 3'b000, AddrDisplay, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromReg, 6'o00};
         StDisplay:
            w = {AluOr, 3'b000, AddrDisplay, 1'b0, 4'h0, 3'b000, SrcBReg, PcFromReg, 6'o01};
         default: w = {AluOr, 24'h0};  // Blank
      endcase
      return w;
   endfunction

   task automatic checkOutputs();
      logic irqNow;
      irqNow = InterruptIn && !InterruptHandler;
      checkValue("CurrentState", 32'(mState), 32'(CurrentState));
      checkValue("NextState", 32'(nextState(mState, Opcode, Functioncode)), 32'(NextState));
      checkValue("CycleCount", 32'(mCycles), 32'(CycleCount));
      checkValue("InstructionCount", 32'(mInstrs), 32'(InstructionCount));
      checkValue("control outputs", 32'(controlWord(mState, Opcode, irqNow)),
                 32'({ALUOp, PCWriteBeq, PCWriteBne, PCWrite, IorD, IRegWrite, WriteAddr,
                      WriteData, SignExt, GRegWrite, ALUSrcA, ALUSrcB, PCData, MemWrite,
                      MemWriteData, EPCWrite, CLR, LCDWrite}));
      if (mState == StFetch)
      begin
         checkValue("Fetch EPCWrite", 32'(irqNow), 32'(EPCWrite));
         checkValue("Fetch PCData", irqNow ? 32'(PcFromVector) : 32'(PcFromAlu), 32'(PCData));
      end
   endtask

   task automatic driveInputs(input logic newInstr);
      int r;
      r = $random(seed);
      InterruptIn      <= (r[2:0] == 3'd0);  // about one in eight
      InterruptHandler <= r[3];
      if (newInstr)
      begin
         r = $random(seed);
         Opcode       <= r[3:0];
         Functioncode <= r[7:4];
      end
   endtask

   initial
   begin
      Reset            = 1'b1;
      Opcode           = '0;
      Functioncode     = '0;
      InterruptIn      = 1'b0;
      InterruptHandler = 1'b0;
      mState  = StFetch;
      mCycles = '0;
      mInstrs = '0;

      repeat (3) @(posedge CLK);
      @(posedge CLK);
      Reset <= 1'b0;
      driveInputs(1'b1);
      @(negedge CLK);
      checkValue("reset PCWrite", 32'd1, 32'(PCWrite));
      checkValue("reset IRegWrite", 32'd1, 32'(IRegWrite));
      checkValue("reset strobes", 32'd0,
                 32'({MemWrite, GRegWrite, LCDWrite, CLR, PCWriteBeq, PCWriteBne}));
      checkOutputs();

      while (instrDone < 2000)
      begin
         @(posedge CLK);
         mNext   = nextState(mState, Opcode, Functioncode);
         mCycles = mCycles + CountWidth'(1);
         if (mState == StFetch)
            mInstrs = mInstrs + CountWidth'(1);
         mState      = mNext;
         instrCycles = instrCycles + 1;
         if (mState == StFetch)
         begin
            checkValue("cycles per instruction", 32'(cyclesFor(Opcode, Functioncode)),
                       32'(instrCycles));
            instrCycles = 0;
            instrDone   = instrDone + 1;
         end
         else if (instrCycles > 6)
         begin
            $display("Timeout: instruction did not return to Fetch within 6 cycles");
            $display(">>> FAIL");
            $fatal(1, "timeout");
         end
         driveInputs(mState == StFetch);
         @(negedge CLK);  // outputs settled
         checkOutputs();
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
common/controlPkg.sv
control/stateSequencer.sv
control/datapathDecoder.sv
hw/perfCounters.sv
hw/multicycleControl.sv
tests/multicycleControl_asserts.sv
tests/multicycleControl_tb.sv

//--- build.sh
#!/bin/sh
# Compile with Verilator and run the multicycleControl testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module multicycleControl_tb \
   -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

output=$(./obj_dir/VmulticycleControl_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with an error"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
